/* common/axi_bus_pkg.sv */
package axi_bus_pkg;

    localparam int axi_id_w = 4;
    localparam int axi_len_w = 4;

    // AXI3 size field, bytes per beat
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010
    } axi_size_t;

    localparam logic [1:0] burst_incr = 2'b01;

    localparam logic [axi_id_w-1:0] mem_id = 4'h1; // same id on ar and aw

    // fixed sideband values
    localparam logic [1:0] lock_normal = 2'b00;
    localparam logic [3:0] cache_none = 4'b0000;
    localparam logic [2:0] prot_none = 3'b000;

endpackage

/* common/mem_req_pkg.sv */
package mem_req_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int strb_w = 4; // one bit per byte lane

    typedef enum logic [1:0] {
        line_fill,
        line_wback,
        unc_read,
        unc_write
    } req_kind_t;

    localparam int default_line_words = 16;

endpackage

/* source/req_decode.sv */
`timescale 1ns/10ps

module req_decode #(
    parameter int line_words = mem_req_pkg::default_line_words
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      req_valid,
    input  mem_req_pkg::req_kind_t                    req_kind,
    input  logic [mem_req_pkg::addr_w-1:0]            req_addr,
    input  logic [mem_req_pkg::strb_w-1:0]            req_sel,
    input  logic [mem_req_pkg::word_w-1:0]            req_wdata,
    input  logic [line_words*mem_req_pkg::word_w-1:0] req_line,
    input  logic                                      taken,
    output logic                                      req_ready,
    output logic                                      rd_start,
    output logic                                      wr_start,
    output logic [mem_req_pkg::addr_w-1:0]            addr,
    output axi_bus_pkg::axi_size_t                    size,
    output logic                                      single,
    output logic [mem_req_pkg::strb_w-1:0]            strb,
    output logic [mem_req_pkg::word_w-1:0]            wdata_word,
    output logic [line_words*mem_req_pkg::word_w-1:0] wdata_line
);

    logic busy;
    logic accept;
    logic is_read;
    logic is_single;
    axi_bus_pkg::axi_size_t req_size;

    assign req_ready = !busy;
    assign accept = req_valid && req_ready;
    assign is_read = (req_kind == mem_req_pkg::line_fill) || (req_kind == mem_req_pkg::unc_read);
    assign is_single = (req_kind == mem_req_pkg::unc_read) ||
                       (req_kind == mem_req_pkg::unc_write);

    always_comb begin
        req_size = axi_bus_pkg::size_word; // lines always move full words
        if (is_single) begin
            case (req_sel)
                4'b0001, 4'b0010, 4'b0100, 4'b1000: req_size = axi_bus_pkg::size_byte;
                4'b0011, 4'b1100: req_size = axi_bus_pkg::size_half;
                default: req_size = axi_bus_pkg::size_word;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= accept && is_read;
            wr_start <= accept && !is_read;
            if (accept) begin
                busy <= 1'b1;
            end else if (taken) begin
                busy <= 1'b0; // response handed off
            end
        end
    end

    // held stable until taken, engines read these directly
    always_ff @(posedge clk) begin
        if (accept) begin
            addr <= req_addr;
            size <= req_size;
            single <= is_single;
            strb <= is_single ? req_sel : '1;
            wdata_word <= req_wdata;
            wdata_line <= req_line;
        end
    end

endmodule

/* bus_engine/read_burst.sv */
`timescale 1ns/10ps

module read_burst #(
    parameter int line_words = mem_req_pkg::default_line_words
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      start,
    input  logic [mem_req_pkg::addr_w-1:0]            addr,
    input  axi_bus_pkg::axi_size_t                    size,
    input  logic                                      single,
    input  logic                                      arready,
    input  logic [mem_req_pkg::word_w-1:0]            rdata,
    input  logic                                      rlast,
    input  logic                                      rvalid,
    output logic [mem_req_pkg::addr_w-1:0]            araddr,
    output logic [axi_bus_pkg::axi_len_w-1:0]         arlen,
    output axi_bus_pkg::axi_size_t                    arsize,
    output logic                                      arvalid,
    output logic                                      rready,
    output logic                                      done,
    output logic [line_words*mem_req_pkg::word_w-1:0] line,
    output logic [mem_req_pkg::word_w-1:0]            word
);

    localparam int beat_w = $clog2(line_words);
    localparam int len_w = axi_bus_pkg::axi_len_w;
    localparam logic [len_w-1:0] burst_len = len_w'(line_words - 1);

    logic [beat_w-1:0] beat;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            arvalid <= 1'b0;
            rready <= 1'b0;
            done <= 1'b0;
            beat <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                arvalid <= 1'b1;
                beat <= '0;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready <= 1'b1; // now wait for R beats
            end else if (rvalid && rready) begin
                beat <= beat + 1'b1;
                if (rlast) begin
                    rready <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= addr;
            arlen <= single ? '0 : burst_len;
            arsize <= size;
        end
        if (rvalid && rready) begin
            if (single) begin
                word <= rdata;
            end else begin
                line[beat * mem_req_pkg::word_w +: mem_req_pkg::word_w] <= rdata; // low word first
            end
        end
    end

endmodule

/* bus_engine/write_burst.sv */
`timescale 1ns/10ps

module write_burst #(
    parameter int line_words = mem_req_pkg::default_line_words
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      start,
    input  logic [mem_req_pkg::addr_w-1:0]            addr,
    input  axi_bus_pkg::axi_size_t                    size,
    input  logic                                      single,
    input  logic [mem_req_pkg::strb_w-1:0]            strb,
    input  logic [mem_req_pkg::word_w-1:0]            wdata_word,
    input  logic [line_words*mem_req_pkg::word_w-1:0] wdata_line,
    input  logic                                      awready,
    input  logic                                      wready,
    input  logic                                      bvalid,
    output logic [mem_req_pkg::addr_w-1:0]            awaddr,
    output logic [axi_bus_pkg::axi_len_w-1:0]         awlen,
    output axi_bus_pkg::axi_size_t                    awsize,
    output logic                                      awvalid,
    output logic [mem_req_pkg::word_w-1:0]            wdata,
    output logic [mem_req_pkg::strb_w-1:0]            wstrb,
    output logic                                      wlast,
    output logic                                      wvalid,
    output logic                                      bready,
    output logic                                      done
);

    localparam int beat_w = $clog2(line_words);
    localparam int len_w = axi_bus_pkg::axi_len_w;
    localparam logic [len_w-1:0] burst_len = len_w'(line_words - 1);
    localparam logic [beat_w-1:0] pre_last = beat_w'(line_words - 2);

    logic [beat_w-1:0] beat;

    // source data is held by req_decode for the whole transfer
    assign wdata = single ? wdata_word
                          : wdata_line[beat * mem_req_pkg::word_w +: mem_req_pkg::word_w];
    assign wstrb = strb; // all ones for lines

    always_ff @(posedge clk) begin
        if (!rstn) begin
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            wlast <= 1'b0;
            bready <= 1'b0;
            done <= 1'b0;
            beat <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                awvalid <= 1'b1;
                beat <= '0;
            end else if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid <= 1'b1;
                wlast <= single;
            end else if (wvalid && wready) begin
                if (wlast) begin
                    wvalid <= 1'b0;
                    wlast <= 1'b0;
                    bready <= 1'b1;
                end else begin
                    beat <= beat + 1'b1;
                    wlast <= (beat == pre_last); // next beat is the final one
                end
            end else if (bvalid && bready) begin
                bready <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            awaddr <= addr;
            awlen <= single ? '0 : burst_len;
            awsize <= size;
        end
    end

endmodule

/* source/resp_return.sv */
`timescale 1ns/10ps

module resp_return #(
    parameter int line_words = mem_req_pkg::default_line_words
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      rd_done,
    input  logic                                      wr_done,
    input  logic [line_words*mem_req_pkg::word_w-1:0] line_in,
    input  logic [mem_req_pkg::word_w-1:0]            word_in,
    input  logic                                      rsp_ready,
    output logic                                      rsp_valid,
    output logic [line_words*mem_req_pkg::word_w-1:0] rsp_line,
    output logic [mem_req_pkg::word_w-1:0]            rsp_word,
    output logic                                      taken
);

    assign taken = rsp_valid && rsp_ready; // frees req_decode next cycle

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else if (rd_done || wr_done) begin
            rsp_valid <= 1'b1;
        end else if (taken) begin
            rsp_valid <= 1'b0;
        end
    end

    // writes return no data, old values stay
    always_ff @(posedge clk) begin
        if (rd_done) begin
            rsp_line <= line_in;
            rsp_word <= word_in;
        end
    end

endmodule

/* source/axi_bridge_top.sv */
`timescale 1ns/10ps

module axi_bridge_top #(
    parameter int line_words = mem_req_pkg::default_line_words
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      req_valid,
    output logic                                      req_ready,
    input  mem_req_pkg::req_kind_t                    req_kind,
    input  logic [mem_req_pkg::addr_w-1:0]            req_addr,
    input  logic [mem_req_pkg::strb_w-1:0]            req_sel,
    input  logic [mem_req_pkg::word_w-1:0]            req_wdata,
    input  logic [line_words*mem_req_pkg::word_w-1:0] req_line,
    output logic                                      rsp_valid,
    input  logic                                      rsp_ready,
    output logic [line_words*mem_req_pkg::word_w-1:0] rsp_line,
    output logic [mem_req_pkg::word_w-1:0]            rsp_word,
    output logic [axi_bus_pkg::axi_id_w-1:0]          arid,
    output logic [mem_req_pkg::addr_w-1:0]            araddr,
    output logic [axi_bus_pkg::axi_len_w-1:0]         arlen,
    output axi_bus_pkg::axi_size_t                    arsize,
    output logic [1:0]                                arburst,
    output logic [1:0]                                arlock,
    output logic [3:0]                                arcache,
    output logic [2:0]                                arprot,
    output logic                                      arvalid,
    input  logic                                      arready,
    input  logic [mem_req_pkg::word_w-1:0]            rdata,
    input  logic                                      rlast,
    input  logic                                      rvalid,
    output logic                                      rready,
    output logic [axi_bus_pkg::axi_id_w-1:0]          awid,
    output logic [mem_req_pkg::addr_w-1:0]            awaddr,
    output logic [axi_bus_pkg::axi_len_w-1:0]         awlen,
    output axi_bus_pkg::axi_size_t                    awsize,
    output logic [1:0]                                awburst,
    output logic [1:0]                                awlock,
    output logic [3:0]                                awcache,
    output logic [2:0]                                awprot,
    output logic                                      awvalid,
    input  logic                                      awready,
    output logic [axi_bus_pkg::axi_id_w-1:0]          wid,
    output logic [mem_req_pkg::word_w-1:0]            wdata,
    output logic [mem_req_pkg::strb_w-1:0]            wstrb,
    output logic                                      wlast,
    output logic                                      wvalid,
    input  logic                                      wready,
    input  logic                                      bvalid,
    output logic                                      bready
);

    logic rd_start;
    logic wr_start;
    logic rd_done;
    logic wr_done;
    logic taken;
    logic single;
    logic [mem_req_pkg::addr_w-1:0] addr;
    axi_bus_pkg::axi_size_t size;
    logic [mem_req_pkg::strb_w-1:0] strb;
    logic [mem_req_pkg::word_w-1:0] wdata_word;
    logic [line_words*mem_req_pkg::word_w-1:0] wdata_line;
    logic [line_words*mem_req_pkg::word_w-1:0] rd_line;
    logic [mem_req_pkg::word_w-1:0] rd_word;

    // constant sideband fields
    assign arid = axi_bus_pkg::mem_id;
    assign arburst = axi_bus_pkg::burst_incr;
    assign arlock = axi_bus_pkg::lock_normal;
    assign arcache = axi_bus_pkg::cache_none;
    assign arprot = axi_bus_pkg::prot_none;
    assign awid = axi_bus_pkg::mem_id;
    assign awburst = axi_bus_pkg::burst_incr;
    assign awlock = axi_bus_pkg::lock_normal;
    assign awcache = axi_bus_pkg::cache_none;
    assign awprot = axi_bus_pkg::prot_none;
    assign wid = axi_bus_pkg::mem_id;

    req_decode #(
        .line_words(line_words)
    ) req_decode_i (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_kind   (req_kind),
        .req_addr   (req_addr),
        .req_sel    (req_sel),
        .req_wdata  (req_wdata),
        .req_line   (req_line),
        .taken      (taken),
        .req_ready  (req_ready),
        .rd_start   (rd_start),
        .wr_start   (wr_start),
        .addr       (addr),
        .size       (size),
        .single     (single),
        .strb       (strb),
        .wdata_word (wdata_word),
        .wdata_line (wdata_line)
    );

    read_burst #(
        .line_words(line_words)
    ) read_burst_i (
        .clk     (clk),
        .rstn    (rstn),
        .start   (rd_start),
        .addr    (addr),
        .size    (size),
        .single  (single),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arvalid (arvalid),
        .rready  (rready),
        .done    (rd_done),
        .line    (rd_line),
        .word    (rd_word)
    );

    write_burst #(
        .line_words(line_words)
    ) write_burst_i (
        .clk        (clk),
        .rstn       (rstn),
        .start      (wr_start),
        .addr       (addr),
        .size       (size),
        .single     (single),
        .strb       (strb),
        .wdata_word (wdata_word),
        .wdata_line (wdata_line),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awvalid    (awvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .bready     (bready),
        .done       (wr_done)
    );

    resp_return #(
        .line_words(line_words)
    ) resp_return_i (
        .clk       (clk),
        .rstn      (rstn),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .line_in   (rd_line),
        .word_in   (rd_word),
        .rsp_ready (rsp_ready),
        .rsp_valid (rsp_valid),
        .rsp_line  (rsp_line),
        .rsp_word  (rsp_word),
        .taken     (taken)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk); // released on the falling edge like other inputs
        rstn = 1'b1;
    end

endmodule

/* tb/axi_slave_model.sv */
`timescale 1ns/10ps

module axi_slave_model #(
    parameter int mem_words = 256
) (
    input  logic                              clk,
    input  logic [mem_req_pkg::addr_w-1:0]    araddr,
    input  logic [axi_bus_pkg::axi_len_w-1:0] arlen,
    input  axi_bus_pkg::axi_size_t            arsize,
    input  logic [1:0]                        arburst,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [mem_req_pkg::word_w-1:0]    rdata,
    output logic                              rlast,
    output logic                              rvalid,
    input  logic                              rready,
    input  logic [mem_req_pkg::addr_w-1:0]    awaddr,
    input  logic [axi_bus_pkg::axi_len_w-1:0] awlen,
    input  axi_bus_pkg::axi_size_t            awsize,
    input  logic [1:0]                        awburst,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [mem_req_pkg::word_w-1:0]    wdata,
    input  logic [mem_req_pkg::strb_w-1:0]    wstrb,
    input  logic                              wlast,
    input  logic                              wvalid,
    output logic                              wready,
    output logic                              bvalid,
    input  logic                              bready
);

    logic [mem_req_pkg::word_w-1:0] mem [mem_words];

    // last transaction seen on each channel
    int ar_count = 0;
    int aw_count = 0;
    int w_beats = 0;
    int w_last_bad = 0;
    logic [axi_bus_pkg::axi_len_w-1:0] ar_len;
    logic [axi_bus_pkg::axi_len_w-1:0] aw_len;
    axi_bus_pkg::axi_size_t ar_size;
    axi_bus_pkg::axi_size_t aw_size;
    logic [1:0] ar_burst;
    logic [1:0] aw_burst;
    logic [mem_req_pkg::strb_w-1:0] w_strb; // and of all strobes in the burst

    initial begin
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'(i) * 32'h9e37_79b1 ^ 32'h0bad_f00d; // differs for every address
        end
    end

    // outputs change on the falling edge and handshakes land on the next rising edge
    initial begin : read_side
        int base;
        int len;
        forever begin
            @(negedge clk);
            if (arvalid === 1'b1) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                arready = 1'b1;
                base = int'(araddr >> 2) % mem_words;
                len = int'(arlen);
                ar_len = arlen;
                ar_size = arsize;
                ar_burst = arburst;
                ar_count++;
                @(negedge clk);
                arready = 1'b0;
                for (int k = 0; k <= len; k++) begin
                    if ($urandom_range(0, 1) == 1) begin
                        rvalid = 1'b0; // gap between beats
                        @(negedge clk);
                    end
                    rdata = mem[(base + k) % mem_words];
                    rlast = (k == len);
                    rvalid = 1'b1;
                    while (rready !== 1'b1) @(negedge clk);
                    @(negedge clk);
                end
                rvalid = 1'b0;
                rlast = 1'b0;
            end
        end
    end

    initial begin : write_side
        int base;
        int len;
        int k;
        logic last;
        forever begin
            @(negedge clk);
            if (awvalid === 1'b1) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                awready = 1'b1;
                base = int'(awaddr >> 2) % mem_words;
                len = int'(awlen);
                aw_len = awlen;
                aw_size = awsize;
                aw_burst = awburst;
                aw_count++;
                w_beats = 0;
                w_last_bad = 0;
                w_strb = '1;
                @(negedge clk);
                awready = 1'b0;
                k = 0;
                last = 1'b0;
                while (!last) begin // burst ends on the beat marked wlast
                    while (wvalid !== 1'b1) @(negedge clk);
                    repeat ($urandom_range(0, 1)) @(negedge clk);
                    wready = 1'b1;
                    for (int b = 0; b < mem_req_pkg::strb_w; b++) begin
                        if (wstrb[b]) begin
                            mem[(base + k) % mem_words][b*8 +: 8] = wdata[b*8 +: 8];
                        end
                    end
                    w_strb &= wstrb;
                    if (wlast !== (k == len)) begin
                        w_last_bad++;
                    end
                    last = (wlast === 1'b1);
                    w_beats++;
                    k++;
                    @(negedge clk);
                    wready = 1'b0;
                end
                repeat ($urandom_range(0, 3)) @(negedge clk);
                bvalid = 1'b1;
                while (bready !== 1'b1) @(negedge clk);
                @(negedge clk);
                bvalid = 1'b0;
            end
        end
    end

endmodule

/* tb/tb_axi_bridge.sv */
`timescale 1ns/10ps

module tb_axi_bridge;

    localparam int line_words = mem_req_pkg::default_line_words;
    localparam int word_w = mem_req_pkg::word_w;
    localparam int line_bits = line_words * word_w;
    localparam int mem_words = 256;
    localparam int num_req = 200;
    localparam int cycle_limit = num_req * (line_words + 40);

    logic clk;
    logic rstn;
    logic req_valid;
    logic req_ready;
    mem_req_pkg::req_kind_t req_kind;
    logic [mem_req_pkg::addr_w-1:0] req_addr;
    logic [mem_req_pkg::strb_w-1:0] req_sel;
    logic [word_w-1:0] req_wdata;
    logic [line_bits-1:0] req_line;
    logic rsp_valid;
    logic rsp_ready;
    logic [line_bits-1:0] rsp_line;
    logic [word_w-1:0] rsp_word;
    logic [axi_bus_pkg::axi_id_w-1:0] arid, awid, wid;
    logic [mem_req_pkg::addr_w-1:0] araddr, awaddr;
    logic [axi_bus_pkg::axi_len_w-1:0] arlen, awlen;
    axi_bus_pkg::axi_size_t arsize, awsize;
    logic [1:0] arburst, awburst, arlock, awlock;
    logic [3:0] arcache, awcache;
    logic [2:0] arprot, awprot;
    logic arvalid, arready, rlast, rvalid, rready;
    logic [word_w-1:0] rdata, wdata;
    logic [mem_req_pkg::strb_w-1:0] wstrb;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    logic [word_w-1:0] model [mem_words];
    int checks = 0;
    int errors = 0;
    int reads = 0;
    int writes = 0;
    int cycles = 0;

    tb_clock_gen clock_gen_i (.*);

    axi_bridge_top #(.line_words(line_words)) axi_bridge_top_i (.*);

    axi_slave_model #(.mem_words(mem_words)) slave_i (.*);

    task automatic compare_value(input string name, input logic [line_bits-1:0] got,
                                 input logic [line_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %0h expected %0h", name, got, exp);
        end
    endtask

    function automatic axi_bus_pkg::axi_size_t size_for_sel(input logic [3:0] sel);
        if ($countones(sel) == 1) begin
            return axi_bus_pkg::size_byte;
        end else if (sel == 4'b0011 || sel == 4'b1100) begin
            return axi_bus_pkg::size_half;
        end
        return axi_bus_pkg::size_word;
    endfunction

    task automatic run_request();
        mem_req_pkg::req_kind_t kind;
        bit single;
        int line_base;
        int idx;
        int nwords;
        logic [line_bits-1:0] exp_line;
        logic [line_bits-1:0] held_line;
        logic [word_w-1:0] held_word;
        axi_bus_pkg::axi_size_t exp_size;
        kind = mem_req_pkg::req_kind_t'(2'($urandom_range(0, 3)));
        single = (kind == mem_req_pkg::unc_read) || (kind == mem_req_pkg::unc_write);
        line_base = int'($urandom_range(0, mem_words / line_words - 1)) * line_words;
        idx = single ? line_base + int'($urandom_range(0, line_words - 1)) : line_base;
        nwords = single ? 1 : line_words;
        req_kind = kind;
        req_addr = 32'(idx * 4);
        req_sel = 4'($urandom_range(0, 15));
        req_wdata = $urandom();
        for (int k = 0; k < line_words; k++) begin
            req_line[k*word_w +: word_w] = $urandom();
            exp_line[k*word_w +: word_w] = model[line_base + k];
        end
        exp_size = single ? size_for_sel(req_sel) : axi_bus_pkg::size_word;
        req_valid = 1'b1;
        while (req_ready !== 1'b1) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        while (rsp_valid !== 1'b1) begin
            compare_value("req_ready", line_bits'(req_ready), '0); // busy until hand-off
            @(negedge clk);
        end
        held_line = rsp_line;
        held_word = rsp_word;
        if (kind == mem_req_pkg::line_fill) begin
            compare_value("rsp_line", rsp_line, exp_line);
        end else if (kind == mem_req_pkg::unc_read) begin
            compare_value("rsp_word", line_bits'(rsp_word), line_bits'(model[idx]));
        end
        repeat ($urandom_range(0, 3)) begin
            @(negedge clk);
            compare_value("rsp_valid", line_bits'(rsp_valid), line_bits'(1'b1));
            compare_value("req_ready", line_bits'(req_ready), '0);
            compare_value("rsp_line", rsp_line, held_line);
            compare_value("rsp_word", line_bits'(rsp_word), line_bits'(held_word));
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        compare_value("rsp_valid", line_bits'(rsp_valid), '0); // one response only
        compare_value("req_ready", line_bits'(req_ready), line_bits'(1'b1));
        if (kind == mem_req_pkg::line_fill || kind == mem_req_pkg::unc_read) begin
            reads++;
            compare_value("ar_count", line_bits'(slave_i.ar_count), line_bits'(reads));
            compare_value("arlen", line_bits'(slave_i.ar_len), line_bits'(nwords - 1));
            compare_value("arsize", line_bits'(slave_i.ar_size), line_bits'(exp_size));
            compare_value("arburst", line_bits'(slave_i.ar_burst),
                          line_bits'(axi_bus_pkg::burst_incr));
        end else begin
            writes++;
            compare_value("aw_count", line_bits'(slave_i.aw_count), line_bits'(writes));
            compare_value("awlen", line_bits'(slave_i.aw_len), line_bits'(nwords - 1));
            compare_value("awsize", line_bits'(slave_i.aw_size), line_bits'(exp_size));
            compare_value("awburst", line_bits'(slave_i.aw_burst),
                          line_bits'(axi_bus_pkg::burst_incr));
            compare_value("w_beats", line_bits'(slave_i.w_beats), line_bits'(nwords));
            compare_value("wlast", line_bits'(slave_i.w_last_bad), '0);
            compare_value("wstrb", line_bits'(slave_i.w_strb),
                          line_bits'(single ? req_sel : 4'hf));
            for (int k = 0; k < line_words; k++) begin
                if (!single) begin
                    model[line_base + k] = req_line[k*word_w +: word_w];
                end
            end
            for (int b = 0; b < mem_req_pkg::strb_w; b++) begin
                if (single && req_sel[b]) begin
                    model[idx][b*8 +: 8] = req_wdata[b*8 +: 8];
                end
            end
            for (int k = 0; k < nwords; k++) begin
                compare_value("mem", line_bits'(slave_i.mem[idx + k]),
                              line_bits'(model[idx + k]));
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles, %0d errors so far",
                     cycle_limit, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h752f));
        req_valid = 1'b0;
        req_kind = mem_req_pkg::line_fill;
        req_addr = '0;
        req_sel = '0;
        req_wdata = '0;
        req_line = '0;
        rsp_ready = 1'b0;
        wait (rstn === 1'b1);
        @(negedge clk);
        for (int i = 0; i < mem_words; i++) begin
            model[i] = slave_i.mem[i]; // start from the slave's initial contents
        end
        compare_value("req_ready", line_bits'(req_ready), line_bits'(1'b1));
        compare_value("arvalid", line_bits'(arvalid), '0);
        compare_value("awvalid", line_bits'(awvalid), '0);
        compare_value("wvalid", line_bits'(wvalid), '0);
        compare_value("wlast", line_bits'(wlast), '0);
        compare_value("rready", line_bits'(rready), '0);
        compare_value("bready", line_bits'(bready), '0);
        compare_value("rsp_valid", line_bits'(rsp_valid), '0);
        // tied-off sideband fields
        compare_value("arid", line_bits'(arid), line_bits'(axi_bus_pkg::mem_id));
        compare_value("awid", line_bits'(awid), line_bits'(axi_bus_pkg::mem_id));
        compare_value("wid", line_bits'(wid), line_bits'(axi_bus_pkg::mem_id));
        compare_value("arlock", line_bits'(arlock), '0);
        compare_value("awlock", line_bits'(awlock), '0);
        compare_value("arcache", line_bits'(arcache), '0);
        compare_value("awcache", line_bits'(awcache), '0);
        compare_value("arprot", line_bits'(arprot), '0);
        compare_value("awprot", line_bits'(awprot), '0);
        repeat (num_req) run_request();
        $display("requests %0d checks %0d errors %0d", num_req, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
common/axi_bus_pkg.sv
common/mem_req_pkg.sv
source/req_decode.sv
bus_engine/read_burst.sv
bus_engine/write_burst.sv
source/resp_return.sv
source/axi_bridge_top.sv
tb/tb_clock_gen.sv
tb/axi_slave_model.sv
tb/tb_axi_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_bridge
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
